/* verilog/mxu_pkg.sv */
// Sizes and shared types of the matrix-vector unit.
// Buffer depths must be powers of two; the FIFO pointers wrap naturally.
// The downstream credit counter holds at most 2**DN_CRD_W-1 unspent credits.
package mxu_pkg;

   // ========================================================================
   // array and flow-control sizes
   // ========================================================================
   localparam int MXU_M     = 4;        // weight rows, results per vector
   localparam int MXU_K     = 4;        // input lanes, array columns
   localparam int LANE_W    = 8;
   localparam int NIB_W     = LANE_W / 2;
   localparam int ACC_W     = 20;
   localparam int IN_DEPTH  = 2;        // producer credits after reset
   localparam int OUT_DEPTH = 4;        // feeder credits after reset

   localparam int ROW_W     = $clog2(MXU_M);
   localparam int IN_PTR_W  = $clog2(IN_DEPTH);
   localparam int IN_CNT_W  = $clog2(IN_DEPTH + 1);
   localparam int OUT_PTR_W = $clog2(OUT_DEPTH);
   localparam int OUT_CNT_W = $clog2(OUT_DEPTH + 1);
   localparam int DN_CRD_W  = 8;

   // issue to result, K columns plus the row wavefront
   localparam int CORE_LAT  = MXU_K + MXU_M - 1;

   // ========================================================================
   // types
   // ========================================================================
   typedef enum logic [0:0] {
      PREC_INT8   = 1'b0,               // one signed byte per lane
      PREC_INT4X2 = 1'b1                // two signed nibbles per lane
   } prec_e;

   typedef logic [LANE_W-1:0]      lane_t;
   typedef lane_t [MXU_K-1:0]      vec_t;
   typedef logic signed [ACC_W-1:0] acc_t;
   typedef acc_t [MXU_M-1:0]       res_t;

endpackage

/* verilog/mxu_res_if.sv */
// Result path from the core to the drain, with the credit pulse back to the feeder.
// valid and credit are single-cycle strobes.
interface mxu_res_if
   import mxu_pkg::*;
();

   logic  valid;     // result strobe
   res_t  res;
   prec_e prec;
   logic  credit;    // one pulse per drain pop

   modport prod (output valid, output res, output prec);

   modport cons (input valid, input res, input prec, output credit);

   modport crd  (input credit);

endinterface

/* verilog/mxu_mac.sv */
// One weight-stationary systolic cell.
// The weight is cleared by reset and loaded through wt_we; it must not change
// while vectors are in flight. Partial sum and passed data are registered.
module mxu_mac
   import mxu_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  wt_we,
   input  lane_t wt_in,
   input  lane_t data_in,
   input  prec_e prec,
   input  acc_t  sum_in,
   output lane_t data_out,
   output acc_t  sum_out
);

   lane_t                      wt_q;
   logic signed [2*LANE_W-1:0] p8;
   logic signed [LANE_W-1:0]   p4_lo;
   logic signed [LANE_W-1:0]   p4_hi;
   acc_t                       prod;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wt_q <= '0;
      end else if (wt_we) begin
         wt_q <= wt_in;
      end
   end

   // both product forms are built, prec picks one
   always_comb begin
      p8    = $signed(wt_q) * $signed(data_in);
      p4_lo = $signed(wt_q[NIB_W-1:0]) * $signed(data_in[NIB_W-1:0]);
      p4_hi = $signed(wt_q[LANE_W-1:NIB_W]) * $signed(data_in[LANE_W-1:NIB_W]);
      if (prec == PREC_INT4X2) begin
         prod = acc_t'(p4_lo) + acc_t'(p4_hi);   // sign extended before the add
      end else begin
         prod = acc_t'(p8);
      end
   end

   always_ff @(posedge clk) begin
      sum_out  <= sum_in + prod;
      data_out <= data_in;                        // moves down to the next row
   end

endmodule

/* verilog/mxu_core.sv */
// MXU_M x MXU_K array of systolic cells.
// Expects lane j skewed by j cycles relative to issue_valid.
// All MXU_M results leave together CORE_LAT cycles after issue.
module mxu_core
   import mxu_pkg::*;
(
   input  logic             clk,
   input  logic             arst_n,
   input  logic             issue_valid,
   input  prec_e            issue_prec,
   input  vec_t             lanes,
   input  logic             wt_we,
   input  logic [ROW_W-1:0] wt_row,
   input  vec_t             wt_data,
   mxu_res_if.prod          res
);

   logic [CORE_LAT-1:0] vld_q;           // bit d is issue_valid delayed d+1
   prec_e               prec_q [CORE_LAT];
   prec_e               cell_prec [MXU_M][MXU_K];
   lane_t               col_data [MXU_M+1][MXU_K];
   acc_t                sum_w [MXU_M][MXU_K+1];
   res_t                row_res;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[CORE_LAT-2:0], issue_valid};
      end
   end

   always_ff @(posedge clk) begin
      prec_q[0] <= issue_prec;
      for (int d = 1; d < CORE_LAT; d++) begin
         prec_q[d] <= prec_q[d-1];
      end
   end

   // ========================================================================
   // cell array
   // ========================================================================
   for (genvar c = 0; c < MXU_K; c++) begin : g_top
      assign col_data[0][c] = lanes[c];
   end

   for (genvar r = 0; r < MXU_M; r++) begin : g_row
      logic row_we;

      assign row_we      = wt_we && (wt_row == ROW_W'(r));
      assign sum_w[r][0] = '0;

      for (genvar c = 0; c < MXU_K; c++) begin : g_col
         // cell (r,c) sees its vector r+c cycles after issue
         if (r + c == 0) begin : g_p0
            assign cell_prec[r][c] = issue_prec;
         end else begin : g_pn
            assign cell_prec[r][c] = prec_q[r+c-1];
         end

         mxu_mac mac_i (
            .clk      (clk),
            .arst_n   (arst_n),
            .wt_we    (row_we),
            .wt_in    (wt_data[c]),
            .data_in  (col_data[r][c]),
            .prec     (cell_prec[r][c]),
            .sum_in   (sum_w[r][c]),
            .data_out (col_data[r+1][c]),
            .sum_out  (sum_w[r][c+1])
         );
      end

      // early rows wait for the last one
      if (r == MXU_M - 1) begin : g_last
         assign row_res[r] = sum_w[r][MXU_K];
      end else begin : g_dly
         acc_t dly_q [MXU_M-1-r];

         always_ff @(posedge clk) begin
            dly_q[0] <= sum_w[r][MXU_K];
            for (int d = 1; d < MXU_M - 1 - r; d++) begin
               dly_q[d] <= dly_q[d-1];
            end
         end

         assign row_res[r] = dly_q[MXU_M-2-r];
      end
   end

   assign res.valid = vld_q[CORE_LAT-1];
   assign res.prec  = prec_q[CORE_LAT-1];
   assign res.res   = row_res;

endmodule

/* verilog/mxu_feeder.sv */
// Input buffer, credit accounting toward the drain and lane skew.
// The producer must hold a credit for every in_valid; there is no overflow check.
// A vector written at one edge can issue at the next edge at the earliest.
module mxu_feeder
   import mxu_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,
   input  logic    in_valid,
   input  prec_e   in_prec,
   input  vec_t    in_vec,
   output logic    in_credit,
   output logic    issue_valid,
   output prec_e   issue_prec,
   output vec_t    lanes,
   mxu_res_if.crd  crd
);

   vec_t                 buf_vec  [IN_DEPTH];
   prec_e                buf_prec [IN_DEPTH];
   logic [IN_PTR_W-1:0]  wr_ptr;
   logic [IN_PTR_W-1:0]  rd_ptr;
   logic [IN_CNT_W-1:0]  buf_cnt;
   logic [OUT_CNT_W-1:0] crd_cnt;           // free drain FIFO slots
   logic                 issue_fire;
   vec_t                 issue_vec;

   assign issue_fire = (buf_cnt != '0) && (crd_cnt != '0);

   always_ff @(posedge clk) begin
      if (in_valid) begin
         buf_vec[wr_ptr]  <= in_vec;
         buf_prec[wr_ptr] <= in_prec;
      end
      if (issue_fire) begin
         issue_vec  <= buf_vec[rd_ptr];
         issue_prec <= buf_prec[rd_ptr];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         buf_cnt     <= '0;
         crd_cnt     <= OUT_CNT_W'(OUT_DEPTH);
         in_credit   <= 1'b0;
         issue_valid <= 1'b0;
      end else begin
         if (in_valid) wr_ptr <= wr_ptr + 1'b1;
         if (issue_fire) rd_ptr <= rd_ptr + 1'b1;
         buf_cnt     <= buf_cnt + IN_CNT_W'(in_valid) - IN_CNT_W'(issue_fire);
         crd_cnt     <= crd_cnt + OUT_CNT_W'(crd.credit) - OUT_CNT_W'(issue_fire);
         in_credit   <= issue_fire;                // slot freed with the issue
         issue_valid <= issue_fire;
      end
   end

   // ========================================================================
   // triangular skew, lane j held back j cycles
   // ========================================================================
   for (genvar j = 0; j < MXU_K; j++) begin : g_skew
      if (j == 0) begin : g_direct
         assign lanes[j] = issue_vec[j];
      end else begin : g_chain
         lane_t skew_q [j];

         always_ff @(posedge clk) begin
            skew_q[0] <= issue_vec[j];
            for (int d = 1; d < j; d++) begin
               skew_q[d] <= skew_q[d-1];
            end
         end

         assign lanes[j] = skew_q[j-1];
      end
   end

endmodule

/* verilog/mxu_drain.sv */
// Result FIFO and downstream credit counter.
// The feeder's credits keep the FIFO from overflowing, so writes are not checked.
// out_valid is a one-cycle strobe, one per credit received on out_credit.
module mxu_drain
   import mxu_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   mxu_res_if.cons  res,
   output logic     out_valid,
   output prec_e    out_prec,
   output res_t     out_res,
   input  logic     out_credit
);

   res_t                 fifo_res  [OUT_DEPTH];
   prec_e                fifo_prec [OUT_DEPTH];
   logic [OUT_PTR_W-1:0] wr_ptr;
   logic [OUT_PTR_W-1:0] rd_ptr;
   logic [OUT_CNT_W-1:0] fifo_cnt;
   logic [DN_CRD_W-1:0]  dn_crd;            // credits granted, not yet spent
   logic                 pop;

   assign pop = (fifo_cnt != '0) && (dn_crd != '0);

   always_ff @(posedge clk) begin
      if (res.valid) begin
         fifo_res[wr_ptr]  <= res.res;
         fifo_prec[wr_ptr] <= res.prec;
      end
      if (pop) begin
         out_res  <= fifo_res[rd_ptr];
         out_prec <= fifo_prec[rd_ptr];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_cnt   <= '0;
         dn_crd     <= '0;
         out_valid  <= 1'b0;
         res.credit <= 1'b0;
      end else begin
         if (res.valid) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         fifo_cnt   <= fifo_cnt + OUT_CNT_W'(res.valid) - OUT_CNT_W'(pop);
         dn_crd     <= dn_crd + DN_CRD_W'(out_credit) - DN_CRD_W'(pop);
         out_valid  <= pop;
         res.credit <= pop;                         // slot handed back to the feeder
      end
   end

endmodule

/* verilog/mxu_top.sv */
// Matrix-vector unit: feeder, systolic core and drain.
// Load weights one row per wt_we before streaming vectors; weight writes with
// vectors in flight give undefined results. Both outer sides use credits:
// IN_DEPTH input credits after reset, out_credit grants one result each.
module mxu_top
   import mxu_pkg::*;
(
   input  logic             clk,
   input  logic             arst_n,
   input  logic             wt_we,
   input  logic [ROW_W-1:0] wt_row,
   input  vec_t             wt_data,
   input  logic             in_valid,
   input  prec_e            in_prec,
   input  vec_t             in_vec,
   output logic             in_credit,
   output logic             out_valid,
   output prec_e            out_prec,
   output res_t             out_res,
   input  logic             out_credit
);

   logic  issue_valid;
   prec_e issue_prec;
   vec_t  lanes;

   mxu_res_if res_bus ();

   mxu_feeder feeder_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .in_valid    (in_valid),
      .in_prec     (in_prec),
      .in_vec      (in_vec),
      .in_credit   (in_credit),
      .issue_valid (issue_valid),
      .issue_prec  (issue_prec),
      .lanes       (lanes),
      .crd         (res_bus.crd)
   );

   mxu_core core_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .issue_valid (issue_valid),
      .issue_prec  (issue_prec),
      .lanes       (lanes),
      .wt_we       (wt_we),
      .wt_row      (wt_row),
      .wt_data     (wt_data),
      .res         (res_bus.prod)
   );

   mxu_drain drain_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .res         (res_bus.cons),
      .out_valid   (out_valid),
      .out_prec    (out_prec),
      .out_res     (out_res),
      .out_credit  (out_credit)
   );

endmodule

/* verif/tb_clk_gen.sv */
// Free-running 10 ns clock and an active-low reset.
// Reset is held for the first 4 cycles and released on a falling edge.
module tb_clk_gen (
   output logic clk,
   output logic arst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;                    // away from the active edge
   end

endmodule

/* verif/mxu_checker.sv */
// Concurrent checks on the credit loops of the matrix-vector unit.
// Bound to mxu_top. FIFO and credit counts come from the feeder and the drain,
// out_credit and out_valid from the top-level ports.
module mxu_checker
   import mxu_pkg::*;
(
   input logic                 clk,
   input logic                 arst_n,
   input logic                 res_valid,
   input logic [OUT_CNT_W-1:0] fifo_cnt,
   input logic [OUT_CNT_W-1:0] crd_cnt,
   input logic                 out_credit,
   input logic                 out_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   int assert_fails = 0;                // failed assertion count
   int granted;                         // out_credit pulses not yet used by out_valid

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         granted <= 0;
      end else begin
         granted <= granted + int'(out_credit) - int'(out_valid);
      end
   end

   // the feeder's credits must keep the drain FIFO from overflowing
   no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n)
      res_valid |-> (fifo_cnt != OUT_CNT_W'(OUT_DEPTH)))
      else begin
         $error("result arrived while the drain FIFO was full");
         assert_fails++;
      end

   out_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid |-> (granted > 0))
      else begin
         $error("out_valid without a granted downstream credit");
         assert_fails++;
      end

   crd_in_range: assert property (@(posedge clk) disable iff (!arst_n)
      crd_cnt <= OUT_CNT_W'(OUT_DEPTH))
      else begin
         $error("feeder credit count above the drain FIFO depth");
         assert_fails++;
      end

endmodule

/* verif/tb_mxu.sv */
// Testbench for the matrix-vector unit.
// Results are compared in order with dot products worked out here from the
// weight and vector table. The producer keeps its own count of input credits;
// out_credit is granted per phase, freely, after a stall or with random gaps.
// Weights are reloaded only between phases, with the array empty.
module tb_mxu
   import mxu_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   // ========================================================================
   // table layout and run limits
   // ========================================================================
   localparam int N_VEC      = 38;
   localparam int N_WSET     = 2;
   localparam int N_PH       = 5;
   localparam int CRD_FREE   = 0;
   localparam int CRD_STALL  = 1;
   localparam int CRD_RANDOM = 2;
   localparam int STALL_CYC  = 40;      // cycles without out_credit
   localparam int VEC_CYC    = 24;      // bound per table entry
   localparam int SETUP_CYC  = 100;
   localparam int WATCHDOG_CYC = N_VEC * VEC_CYC + STALL_CYC + SETUP_CYC;

   // precision kinds per phase are int8 (0), int4x2 (1), alternating (2) and random (3)
   localparam int PH_FIRST [N_PH] = '{0, 6, 10, 18, 26};
   localparam int PH_COUNT [N_PH] = '{6, 4, 8, 8, 12};
   localparam int PH_WSET  [N_PH] = '{0, 0, 1, 1, 0};
   localparam int PH_PREC  [N_PH] = '{0, 1, 2, 2, 3};
   localparam int PH_MODE  [N_PH] = '{CRD_FREE, CRD_FREE, CRD_FREE, CRD_STALL, CRD_RANDOM};

   logic             clk;
   logic             arst_n;
   logic             wt_we;
   logic [ROW_W-1:0] wt_row;
   vec_t             wt_data;
   logic             in_valid;
   prec_e            in_prec;
   vec_t             in_vec;
   logic             in_credit;
   logic             out_valid;
   prec_e            out_prec;
   res_t             out_res;
   logic             out_credit;

   vec_t             wset [N_WSET][MXU_M];
   vec_t             tab_vec  [N_VEC];
   prec_e            tab_prec [N_VEC];
   int               tab_wset [N_VEC];
   res_t             tab_exp  [N_VEC];
   int               in_crd = IN_DEPTH;  // producer credits held
   logic [31:0]      lfsr_q = 32'h5ed20304;

   tb_clk_gen clk_gen_i (
      .clk    (clk),
      .arst_n (arst_n)
   );

   mxu_top dut_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .wt_we      (wt_we),
      .wt_row     (wt_row),
      .wt_data    (wt_data),
      .in_valid   (in_valid),
      .in_prec    (in_prec),
      .in_vec     (in_vec),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_prec   (out_prec),
      .out_res    (out_res),
      .out_credit (out_credit)
   );

   bind mxu_top mxu_checker chk_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .res_valid  (res_bus.valid),
      .fifo_cnt   (drain_i.fifo_cnt),
      .crd_cnt    (feeder_i.crd_cnt),
      .out_credit (out_credit),
      .out_valid  (out_valid)
   );

   // ========================================================================
   // helpers
   // ========================================================================
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // signed dot product of one weight row with one vector
   function automatic acc_t row_dot(input vec_t w, input vec_t x, input prec_e p);
      int sum;
      sum = 0;
      for (int k = 0; k < MXU_K; k++) begin
         if (p == PREC_INT8) begin
            sum += int'($signed(w[k])) * int'($signed(x[k]));
         end else begin
            sum += int'($signed(w[k][NIB_W-1:0])) * int'($signed(x[k][NIB_W-1:0]));
            sum += int'($signed(w[k][LANE_W-1:NIB_W])) * int'($signed(x[k][LANE_W-1:NIB_W]));
         end
      end
      return acc_t'(sum);
   endfunction

   task automatic abort_run(input string why);
      $display("Test failures found");
      $fatal(1, "%s", why);
   endtask

   task automatic check_res(input res_t got, input res_t exp, input int idx);
      if (got !== exp) begin
         $display("ERR %0t: vector %0d result %h, expected %h", $time, idx, got, exp);
         abort_run("result mismatch");
      end
   endtask

   task automatic check_prec(input prec_e got, input prec_e exp, input int idx);
      if (got !== exp) begin
         $display("ERR %0t: vector %0d precision %s, expected %s",
                  $time, idx, got.name(), exp.name());
         abort_run("precision tag mismatch");
      end
   endtask

   task automatic build_table();
      wset[0][0] = {8'h7f, 8'h80, 8'h01, 8'hff};
      wset[0][1] = {8'h80, 8'h80, 8'h80, 8'h80};
      wset[0][2] = {8'h12, 8'hf7, 8'h88, 8'h3c};
      wset[0][3] = {8'h00, 8'h7f, 8'hc5, 8'h69};
      for (int r = 0; r < MXU_M; r++) begin
         for (int k = 0; k < MXU_K; k++) begin
            wset[1][r][k] = lane_t'(take_bits(LANE_W));
         end
      end
      for (int p = 0; p < N_PH; p++) begin
         for (int i = PH_FIRST[p]; i < PH_FIRST[p] + PH_COUNT[p]; i++) begin
            for (int k = 0; k < MXU_K; k++) begin
               tab_vec[i][k] = lane_t'(take_bits(LANE_W));
            end
            tab_wset[i] = PH_WSET[p];
            case (PH_PREC[p])
               0:       tab_prec[i] = PREC_INT8;
               1:       tab_prec[i] = PREC_INT4X2;
               2:       tab_prec[i] = (i % 2 == 1) ? PREC_INT4X2 : PREC_INT8;
               default: tab_prec[i] = (take_bits(1) == 1) ? PREC_INT4X2 : PREC_INT8;
            endcase
         end
      end
      // extremes of both number formats
      tab_vec[0] = {8'h80, 8'h80, 8'h80, 8'h80};
      tab_vec[1] = {8'h7f, 8'h7f, 8'h7f, 8'h7f};
      tab_vec[6] = {8'h88, 8'h88, 8'h88, 8'h88};
      tab_vec[7] = {8'h7f, 8'hf7, 8'h80, 8'h08};
      for (int i = 0; i < N_VEC; i++) begin
         for (int r = 0; r < MXU_M; r++) begin
            tab_exp[i][r] = row_dot(wset[tab_wset[i]][r], tab_vec[i], tab_prec[i]);
         end
      end
   endtask

   task automatic load_weights(input int ws);
      for (int r = 0; r < MXU_M; r++) begin
         @(negedge clk);
         wt_we   = 1'b1;
         wt_row  = ROW_W'(r);
         wt_data = wset[ws][r];
      end
      @(negedge clk);
      wt_we = 1'b0;
   endtask

   // streams one slice of the table and checks every result in order
   task automatic run_phase(input int first, input int count, input int mode);
      int   cyc;
      int   sent;
      int   got;
      int   pend;                       // granted and result not yet seen
      int   stall_crd;
      logic grant;
      cyc       = 0;
      sent      = 0;
      got       = 0;
      pend      = 0;
      stall_crd = 0;
      while (got < count) begin
         @(negedge clk);
         cyc++;
         if (in_credit) begin
            in_crd++;
            if (mode == CRD_STALL && cyc <= STALL_CYC) stall_crd++;
         end
         if (out_valid) begin
            if (pend == 0) begin
               abort_run($sformatf("out_valid at %0t without a granted credit", $time));
            end
            pend--;
            check_res(out_res, tab_exp[first+got], first + got);
            check_prec(out_prec, tab_prec[first+got], first + got);
            got++;
         end
         if (mode == CRD_STALL && cyc == STALL_CYC) begin
            if (stall_crd > IN_DEPTH + OUT_DEPTH) begin
               $display("ERR %0t: %0d input credits while stalled, limit %0d",
                        $time, stall_crd, IN_DEPTH + OUT_DEPTH);
               abort_run("too many input credits under back-pressure");
            end
            if (sent >= count) abort_run("input kept flowing with no out_credit");
         end
         case (mode)
            CRD_STALL:  grant = (cyc >= STALL_CYC);
            CRD_RANDOM: grant = (take_bits(2) != 0);   // gap one cycle in four
            default:    grant = 1'b1;
         endcase
         out_credit = grant && (pend < count - got);
         if (out_credit) pend++;
         if (sent < count && in_crd > 0) begin
            in_valid = 1'b1;
            in_prec  = tab_prec[first+sent];
            in_vec   = tab_vec[first+sent];
            sent++;
            in_crd--;
         end else begin
            in_valid = 1'b0;
         end
      end
      in_valid   = 1'b0;
      out_credit = 1'b0;
   endtask

   // ========================================================================
   // main sequence
   // ========================================================================
   initial begin
      wt_we      = 1'b0;
      wt_row     = '0;
      wt_data    = '0;
      in_valid   = 1'b0;
      in_prec    = PREC_INT8;
      in_vec     = '0;
      out_credit = 1'b0;
      build_table();
      wait (arst_n === 1'b1);
      repeat (3) begin
         @(negedge clk);
         if (in_credit !== 1'b0 || out_valid !== 1'b0) begin
            $display("ERR %0t: in_credit %b out_valid %b after reset, expected 0 0",
                     $time, in_credit, out_valid);
            abort_run("outputs active after reset");
         end
      end
      for (int p = 0; p < N_PH; p++) begin
         load_weights(PH_WSET[p]);
         run_phase(PH_FIRST[p], PH_COUNT[p], PH_MODE[p]);
      end
      repeat (4) @(negedge clk);
      if (dut_i.chk_i.assert_fails == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         $display("Test failures found");
         $fatal(1, "%0d assertion failures", dut_i.chk_i.assert_fails);
      end
   end

   initial begin
      repeat (WATCHDOG_CYC) @(posedge clk);
      abort_run($sformatf("watchdog timeout after %0d cycles", WATCHDOG_CYC));
   end

endmodule

/* flist.f */
verilog/mxu_pkg.sv
verilog/mxu_res_if.sv
verilog/mxu_mac.sv
verilog/mxu_core.sv
verilog/mxu_feeder.sv
verilog/mxu_drain.sv
verilog/mxu_top.sv
verif/tb_clk_gen.sv
verif/mxu_checker.sv
verif/tb_mxu.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
   -f flist.f --top-module tb_mxu -o tb_mxu
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/tb_mxu 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qxF 'All tests passed!'; then
   exit 0
fi
exit 1
